// ==== rtl/proc_params.svh ====
// Core size macros for word width, register count and data memory depth
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data word width and PC width
`define PROC_XLEN 16

// Architectural registers including a writable r0
`define PROC_NREGS 8

// Data memory words with addresses wrapping modulo depth
`define PROC_DMEM_DEPTH 64

`endif

// ==== rtl/isaPkg.sv ====
// ISA types with opcode and function enums, R and I formats and the instruction union
`include "proc_params.svh"

package isaPkg;

    typedef logic [$clog2(`PROC_NREGS)-1:0] regIdxT; // Register specifier

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ALU  = 4'd1,                               // R format
        OP_ADDI = 4'd2,
        OP_LD   = 4'd3,
        OP_ST   = 4'd4,                               // Stores reg rd
        OP_BEQZ = 4'd5,
        OP_HALT = 4'd15                               // Remaining codes illegal
    } opcodeE;

    typedef enum logic [2:0] {
        F_ADD = 3'd0,
        F_SUB = 3'd1,
        F_AND = 3'd2,
        F_OR  = 3'd3,
        F_XOR = 3'd4                                  // 5..7 illegal
    } funcE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOpE;

    typedef struct packed {
        opcodeE opcode;                               // [15:12]
        regIdxT rd;                                   // [11:9]
        regIdxT rs;                                   // [8:6]
        regIdxT rt;                                   // [5:3]
        funcE   funct;                                // [2:0]
    } rTypeT;

    typedef struct packed {
        opcodeE      opcode;
        regIdxT      rd;
        regIdxT      rs;
        logic [5:0]  imm6;                            // Signed offset
    } iTypeT;

    // One fetched word viewed in either format
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

endpackage

// ==== rtl/pipePkg.sv ====
// Pipeline types for the control bundle, stage registers and retire record
`include "proc_params.svh"

package pipePkg;

    import isaPkg::*;

    typedef logic [`PROC_XLEN-1:0] wordT;

    typedef struct packed {
        logic  regWrite;                              // Writes rd at retire
        logic  memRead;                               // LD
        logic  memWrite;                              // ST
        logic  useImm;                                // Operand B is imm
        logic  isBranch;                              // BEQZ
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic  valid;
        wordT  pc;
        instrU instr;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        wordT   pc;                                   // For branch target
        regIdxT rd;
        wordT   rsVal;
        wordT   rtVal;                                // rt value or rd value for ST
        wordT   imm;                                  // Sign extended
        ctrlT   ctrl;
    } idExT;

    typedef struct packed {
        logic   valid;
        regIdxT rd;
        wordT   aluOut;                               // Result or address
        wordT   storeVal;
        ctrlT   ctrl;
    } exMemT;

    typedef struct packed {
        regIdxT regIdx;                               // Register written
        wordT   data;
    } retireT;

endpackage

// ==== rtl/fetch.sv ====
// Fetch stage with PC, instruction port handshake and IF/ID register
`include "proc_params.svh"

module fetch import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  halted,
    input  logic [`PROC_XLEN-1:0] branchTarget,
    output logic                  imemValid,
    output logic [`PROC_XLEN-1:0] imemAddr,
    input  logic                  imemReady,
    input  instrU                 imemInstr,
    output ifIdT                  ifId
);

    logic [`PROC_XLEN-1:0] pc;
    logic                  accept;                // Fetch taken this cycle

    assign imemAddr  = pc;
    assign imemValid = !(halted || stall || flush); // No request while held or redirecting
    assign accept    = imemValid && imemReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (flush) begin
            pc         <= branchTarget;           // Taken BEQZ redirect
            ifId.valid <= 1'b0;                   // Drop wrong path word
        end else if (!stall) begin
            ifId.valid <= accept;                 // Bubble on refused fetch
            if (accept) pc <= pc + 1'b1;
        end
    end

    // Payload loads only on an accepted fetch
    always_ff @(posedge clk) begin
        if (accept) begin
            ifId.pc    <= pc;
            ifId.instr <= imemInstr;
        end
    end

endmodule

// ==== rtl/decode.sv ====
// Decode stage with register file, operand read, imm6 sign extension and ID/EX register
`include "proc_params.svh"

module decode import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  ifIdT                  ifId,
    input  ctrlT                  ctrl,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wbEn,
    input  regIdxT                wbReg,
    input  logic [`PROC_XLEN-1:0] wbData,
    output idExT                  idEx
);

    wordT   regs [`PROC_NREGS];                   // r0 writable like the rest
    instrU  instr;
    regIdxT rsIdx;
    regIdxT rtIdx;                                // Second source
    wordT   rsVal;
    wordT   rtVal;
    wordT   imm;

    assign instr = ifId.instr;
    assign rsIdx = instr.r.rs;                    // Same bits in both formats

    // ALU reads rt while ST reads its data register from the rd slot
    assign rtIdx = ctrl.memWrite ? instr.i.rd : instr.r.rt;

    // Write through a retiring result in the same cycle
    assign rsVal = (wbEn && wbReg == rsIdx) ? wbData : regs[rsIdx];
    assign rtVal = (wbEn && wbReg == rtIdx) ? wbData : regs[rtIdx];

    assign imm = {{(`PROC_XLEN-6){instr.i.imm6[5]}}, instr.i.imm6};

    always_ff @(posedge clk) begin
        if (wbEn) regs[wbReg] <= wbData;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
            idEx.ctrl  <= '0;
        end else if (stall || flush) begin
            idEx.valid <= 1'b0;                   // Bubble into EX
            idEx.ctrl  <= '0;
        end else begin
            idEx.valid <= ifId.valid;
            idEx.ctrl  <= ctrl;
        end
    end

    // Operands and immediate
    always_ff @(posedge clk) begin
        idEx.pc    <= ifId.pc;
        idEx.rd    <= instr.r.rd;
        idEx.rsVal <= rsVal;
        idEx.rtVal <= rtVal;
        idEx.imm   <= imm;
    end

endmodule

// ==== rtl/execute.sv ====
// Execute stage with operand select, ALU, BEQZ resolution and EX/MEM register
`include "proc_params.svh"

module execute import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  idExT                  idEx,
    output exMemT                 exMem,
    output logic                  branchTaken,
    output logic [`PROC_XLEN-1:0] branchTarget
);

    wordT opB;
    wordT aluOut;

    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: aluOut = idEx.rsVal + opB;   // Also LD/ST address
            ALU_SUB: aluOut = idEx.rsVal - opB;
            ALU_AND: aluOut = idEx.rsVal & opB;
            ALU_OR:  aluOut = idEx.rsVal | opB;
            ALU_XOR: aluOut = idEx.rsVal ^ opB;
            default: aluOut = '0;
        endcase
    end

    assign branchTaken  = idEx.valid && idEx.ctrl.isBranch && (idEx.rsVal == '0);
    assign branchTarget = idEx.pc + 1'b1 + idEx.imm; // Relative to next word

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
            exMem.ctrl  <= '0;
        end else begin
            exMem.valid <= idEx.valid;            // Branch passes on and writes nothing
            exMem.ctrl  <= idEx.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        exMem.rd       <= idEx.rd;
        exMem.aluOut   <= aluOut;
        exMem.storeVal <= idEx.rtVal;
    end

endmodule

// ==== rtl/memory.sv ====
// Memory stage with word addressed data RAM, load/store, writeback select and retire port
`include "proc_params.svh"

module memory import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  exMemT                 exMem,
    output logic                  wbEn,
    output regIdxT                wbReg,
    output logic [`PROC_XLEN-1:0] wbData,
    output logic                  retireValid,
    output retireT                retireRec
);

    wordT                                dmem [`PROC_DMEM_DEPTH];
    logic [$clog2(`PROC_DMEM_DEPTH)-1:0] addr;    // Wraps modulo depth
    wordT                                loadVal;

    assign addr    = exMem.aluOut[$clog2(`PROC_DMEM_DEPTH)-1:0];
    assign loadVal = dmem[addr];                  // Async read

    // No stores while reset is held
    always_ff @(posedge clk) begin
        if (rstN && exMem.valid && exMem.ctrl.memWrite) begin
            dmem[addr] <= exMem.storeVal;
        end
    end

    assign wbEn   = exMem.valid && exMem.ctrl.regWrite;
    assign wbReg  = exMem.rd;
    assign wbData = exMem.ctrl.memRead ? loadVal : exMem.aluOut;

    // Retire mirrors the register file write
    assign retireValid      = wbEn;
    assign retireRec.regIdx = wbReg;
    assign retireRec.data   = wbData;

endmodule

// ==== rtl/control.sv ====
// Control with opcode decoder, RAW hazard stall, branch flush and sticky halt and error flags
module control import isaPkg::*, pipePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  ifIdT  ifId,
    input  idExT  idEx,
    input  exMemT exMem,
    input  logic  branchTaken,
    output ctrlT  ctrl,
    output logic  stall,
    output logic  flush,
    output logic  halted,
    output logic  err
);

    instrU  instr;
    ctrlT   ctrlD;                                // Raw decode
    logic   illegal;
    logic   isHalt;
    logic   useRs;
    logic   useRt;
    regIdxT src2;
    logic   haltNow;                              // HALT or trap in live ID slot
    logic   haltQ;
    logic   errQ;

    assign instr = ifId.instr;

    always_comb begin
        ctrlD   = '0;
        illegal = 1'b0;
        isHalt  = 1'b0;
        useRs   = 1'b0;
        useRt   = 1'b0;
        case (instr.r.opcode)
            OP_NOP:  ctrlD = '0;
            OP_ALU: begin
                ctrlD.regWrite = 1'b1;
                useRs          = 1'b1;
                useRt          = 1'b1;
                case (instr.r.funct)
                    F_ADD:   ctrlD.aluOp = ALU_ADD;
                    F_SUB:   ctrlD.aluOp = ALU_SUB;
                    F_AND:   ctrlD.aluOp = ALU_AND;
                    F_OR:    ctrlD.aluOp = ALU_OR;
                    F_XOR:   ctrlD.aluOp = ALU_XOR;
                    default: illegal     = 1'b1;  // Unused funct
                endcase
            end
            OP_ADDI: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.useImm   = 1'b1;
                useRs          = 1'b1;
            end
            OP_LD: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.memRead  = 1'b1;
                ctrlD.useImm   = 1'b1;
                useRs          = 1'b1;
            end
            OP_ST: begin
                ctrlD.memWrite = 1'b1;
                ctrlD.useImm   = 1'b1;            // Address is rs + imm
                useRs          = 1'b1;
                useRt          = 1'b1;            // Data from rd slot
            end
            OP_BEQZ: begin
                ctrlD.isBranch = 1'b1;
                useRs          = 1'b1;
            end
            OP_HALT: isHalt  = 1'b1;
            default: illegal = 1'b1;
        endcase
        if (illegal) ctrlD = '0;                  // Trapped word does nothing
    end

    assign src2 = (instr.r.opcode == OP_ST) ? instr.i.rd : instr.r.rt;
    assign ctrl = ifId.valid ? ctrlD : '0;

    // Pending write to src by an older instruction in EX or MEM
    function automatic logic inFlight(regIdxT src);
        logic inEx;
        logic inMem;
        inEx  = idEx.valid && idEx.ctrl.regWrite && (idEx.rd == src);
        inMem = exMem.valid && exMem.ctrl.regWrite && (exMem.rd == src);
        return inEx || inMem;
    endfunction

    always_comb begin
        stall = ifId.valid && ((useRs && inFlight(instr.r.rs)) || (useRt && inFlight(src2)));
    end

    assign flush   = branchTaken;                 // ID/IF are younger than the branch
    assign haltNow = ifId.valid && !flush && (isHalt || illegal);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            haltQ <= 1'b0;
            errQ  <= 1'b0;
        end else begin
            haltQ <= haltQ || haltNow;            // Sticky until reset
            errQ  <= errQ || (haltNow && illegal);
        end
    end

    // Flags rise in the ID cycle so the next word is never fetched
    assign halted = haltQ || haltNow;
    assign err    = errQ || (haltNow && illegal);

endmodule

// ==== rtl/proc.sv ====
// Core top level connecting fetch, decode, execute and memory stages with control
`include "proc_params.svh"

module proc import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    output logic                  imemValid,
    output logic [`PROC_XLEN-1:0] imemAddr,
    input  logic                  imemReady,
    input  instrU                 imemInstr,
    output logic                  retireValid,
    output retireT                retireRec,
    output logic                  halted,
    output logic                  err
);

    ifIdT   ifId;
    idExT   idEx;
    exMemT  exMem;
    ctrlT   ctrl;                                 // Decoded bundle for ID
    logic   stall;
    logic   flush;
    logic   branchTaken;
    wordT   branchTarget;
    logic   wbEn;                                 // Register file write port
    regIdxT wbReg;
    wordT   wbData;

    fetch fetchStage (
        .clk(clk), .rstN(rstN),
        .stall(stall), .flush(flush), .halted(halted),
        .branchTarget(branchTarget),
        .imemValid(imemValid), .imemAddr(imemAddr),
        .imemReady(imemReady), .imemInstr(imemInstr),
        .ifId(ifId)
    );

    decode decodeStage (
        .clk(clk), .rstN(rstN),
        .ifId(ifId), .ctrl(ctrl),
        .stall(stall), .flush(flush),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .idEx(idEx)
    );

    execute executeStage (
        .clk(clk), .rstN(rstN),
        .idEx(idEx), .exMem(exMem),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    memory memoryStage (
        .clk(clk), .rstN(rstN),
        .exMem(exMem),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .retireValid(retireValid), .retireRec(retireRec)
    );

    control ctrlUnit (
        .clk(clk), .rstN(rstN),
        .ifId(ifId), .idEx(idEx), .exMem(exMem),
        .branchTaken(branchTaken),
        .ctrl(ctrl), .stall(stall), .flush(flush),
        .halted(halted), .err(err)
    );

endmodule

// ==== sim/tbClock.sv ====
// Testbench clock and reset generator with 20 unit period and 3 cycle reset
module tbClock (
    output logic clk,
    output logic rstN,
    input  logic resetReq                         // Restarts the reset window
);

    int holdCnt;

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;                           // Reset from time zero
        holdCnt = 3;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (resetReq) begin
            rstN    <= 1'b0;
            holdCnt <= 3;
        end else if (holdCnt > 0) begin
            holdCnt <= holdCnt - 1;
            if (holdCnt == 1) rstN <= 1'b1;       // Release after third cycle
        end
    end

endmodule

// ==== sim/proc_checker.sv ====
// Port assertions for sticky flags, fetch address hold and quiet retire in reset
`include "proc_params.svh"

module proc_checker (
    input logic                  clk,
    input logic                  rstN,
    input logic                  imemValid,
    input logic [`PROC_XLEN-1:0] imemAddr,
    input logic                  imemReady,
    input logic                  retireValid,
    input logic                  halted,
    input logic                  err
);

    stickyHalt: assert property (@(posedge clk) rstN |-> !$fell(halted))
        else $error("halted fell without reset");

    stickyErr: assert property (@(posedge clk) rstN |-> !$fell(err))
        else $error("err fell without reset");

    // Refused request keeps its address
    addrHold: assert property (@(posedge clk) disable iff (!rstN)
        imemValid && !imemReady |=> $stable(imemAddr))
        else $error("imemAddr changed while request pending");

    quietReset: assert property (@(posedge clk) !rstN ##1 !rstN |-> !retireValid)
        else $error("retireValid high during reset");

endmodule

bind proc proc_checker chk (.*);

// ==== sim/procTb.sv ====
// Core testbench with instruction memory model, ISA reference model and directed tests
`include "proc_params.svh"

module procTb import isaPkg::*, pipePkg::*;;

    logic                  clk;
    logic                  rstN;
    logic                  resetReq;
    logic                  imemValid;
    logic [`PROC_XLEN-1:0] imemAddr;
    logic                  imemReady;
    instrU                 imemInstr;
    logic                  retireValid;
    retireT                retireRec;
    logic                  halted;
    logic                  err;

    logic [15:0] progMem [64];                    // Program words
    int          progLen;
    logic        randomReady;                     // Back-pressure on or off
    logic [31:0] lcgState;
    logic [2:0]  expReg [$];
    logic [15:0] expData [$];
    logic [2:0]  gotReg [$];
    logic [15:0] gotData [$];
    logic        expErr;

    tbClock clkGen (.clk(clk), .rstN(rstN), .resetReq(resetReq));

    proc dut (
        .clk(clk), .rstN(rstN),
        .imemValid(imemValid), .imemAddr(imemAddr),
        .imemReady(imemReady), .imemInstr(imemInstr),
        .retireValid(retireValid), .retireRec(retireRec),
        .halted(halted), .err(err)
    );

    // Words past the program read as HALT
    always_comb begin
        imemInstr = (imemAddr < progLen) ? progMem[imemAddr[5:0]] : 16'hF000;
    end

    function automatic logic nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[16];                      // Upper bits are better mixed
    endfunction

    always @(posedge clk) begin
        if (randomReady) imemReady <= nextRand();
        else imemReady <= 1'b1;
    end

    function automatic logic [15:0] rWord(int funct, int rd, int rs, int rt);
        return {4'd1, 3'(rd), 3'(rs), 3'(rt), 3'(funct)};
    endfunction

    function automatic logic [15:0] iWord(int op, int rd, int rs, int imm);
        return {4'(op), 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    task automatic emit(logic [15:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic stopRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkValue(string sig, logic [15:0] expVal, logic [15:0] gotVal);
        assert (gotVal === expVal) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, expVal, gotVal);
            stopRun();
        end
    endtask

    // Interprets the program word by word with ISA semantics only
    task automatic refRun();
        logic [15:0] r [8];
        logic [15:0] m [64];
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] imm;
        logic [15:0] a;
        logic [15:0] res;
        logic [5:0]  ea;
        logic        done;
        int          steps;
        foreach (r[i]) r[i] = '0;
        foreach (m[i]) m[i] = '0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        expErr = 1'b0;
        expReg.delete();
        expData.delete();
        while (!done && steps < 1000) begin
            w   = (pc < progLen) ? progMem[pc[5:0]] : 16'hF000;
            imm = {{10{w[5]}}, w[5:0]};
            a   = r[w[8:6]];
            ea  = 6'(a + imm);                    // Word address mod 64
            pc  = pc + 1;
            steps++;
            case (w[15:12])
                4'd0: ;
                4'd1: begin
                    case (w[2:0])
                        3'd0: res = a + r[w[5:3]];
                        3'd1: res = a - r[w[5:3]];
                        3'd2: res = a & r[w[5:3]];
                        3'd3: res = a | r[w[5:3]];
                        3'd4: res = a ^ r[w[5:3]];
                        default: done = 1'b1;     // Bad funct traps
                    endcase
                    expErr = done;
                    if (!done) begin
                        r[w[11:9]] = res;
                        expReg.push_back(w[11:9]);
                        expData.push_back(res);
                    end
                end
                4'd2, 4'd3: begin
                    res = (w[15:12] == 4'd2) ? a + imm : m[ea];
                    r[w[11:9]] = res;
                    expReg.push_back(w[11:9]);
                    expData.push_back(res);
                end
                4'd4: m[ea] = r[w[11:9]];
                4'd5: if (a == '0) pc = pc + imm; // Target is pc+1+imm
                4'd15: done = 1'b1;
                default: begin
                    done = 1'b1;
                    expErr = 1'b1;
                end
            endcase
        end
    endtask

    task automatic applyReset();
        int cycles;
        @(posedge clk);
        resetReq <= 1'b1;
        @(posedge clk);
        resetReq <= 1'b0;
        // Zero the register file so it starts like the model
        for (int i = 0; i < `PROC_NREGS; i++) dut.decodeStage.regs[i] = '0;
        cycles = 0;
        do begin                                  // rstN falls at this edge and is seen from the next
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: reset was never released");
                stopRun();
            end
        end while (!rstN);
    endtask

    // Records retires until halted and the older instructions have drained
    task automatic collectRetires(string name);
        int cycles;
        cycles = 0;
        gotReg.delete();
        gotData.delete();
        forever begin
            @(negedge clk);
            if (retireValid) begin
                gotReg.push_back(retireRec.regIdx);
                gotData.push_back(retireRec.data);
            end
            if (halted && !dut.idEx.valid && !dut.exMem.valid) break;
            cycles++;
            if (cycles > 2000) begin
                $display("Timeout: core did not halt in test %s", name);
                stopRun();
            end
        end
    endtask

    task automatic runProgram(string name, logic rnd);
        randomReady = rnd;
        refRun();
        applyReset();
        collectRetires(name);
        checkValue({name, " retire count"}, 16'(expReg.size()), 16'(gotReg.size()));
        foreach (expReg[i]) begin
            checkValue({name, " retireRec.regIdx"}, 16'(expReg[i]), 16'(gotReg[i]));
            checkValue({name, " retireRec.data"}, expData[i], gotData[i]);
        end
        checkValue({name, " err"}, 16'(expErr), 16'(err));
        checkValue({name, " imemValid"}, 16'd0, 16'(imemValid));
    endtask

    task automatic aluTest();
        progLen = 0;
        emit(iWord(2, 1, 0, 5));
        emit(iWord(2, 2, 0, -3));                 // Negative immediate
        for (int f = 0; f < 5; f++) emit(rWord(f, 3 + f % 4, 1, 2));
        emit(iWord(2, 4, 1, -32));
        emit(iWord(2, 5, 2, 31));
        emit(iWord(15, 0, 0, 0));
        runProgram("alu", 1'b0);
    endtask

    task automatic memTest();
        progLen = 0;
        emit(iWord(2, 1, 0, 21));
        emit(iWord(2, 2, 0, 10));
        emit(iWord(4, 1, 2, 0));                  // mem[10] = r1
        emit(iWord(3, 3, 2, 0));
        emit(iWord(2, 4, 0, 30));
        emit(iWord(2, 4, 4, 30));
        emit(iWord(4, 2, 4, 14));                 // 74 wraps to 10
        emit(iWord(3, 5, 0, 10));
        emit(iWord(2, 7, 5, 1));                  // Load-use
        emit(iWord(15, 0, 0, 0));
        runProgram("mem", 1'b0);
    endtask

    task automatic depTest();
        progLen = 0;
        emit(iWord(2, 1, 0, 1));
        emit(iWord(2, 1, 1, 1));
        emit(rWord(0, 2, 1, 1));
        emit(iWord(4, 2, 0, 3));
        emit(iWord(3, 3, 0, 3));
        emit(rWord(0, 4, 3, 3));
        emit(rWord(1, 5, 4, 2));
        emit(iWord(15, 0, 0, 0));
        runProgram("dep", 1'b0);
    endtask

    task automatic branchTest(logic rnd);
        progLen = 0;
        emit(iWord(2, 1, 0, 2));
        emit(iWord(5, 0, 1, 2));                  // Not taken
        emit(iWord(2, 2, 0, 7));
        emit(iWord(5, 0, 0, 2));                  // Taken and skips two
        emit(16'h7000);                           // Illegal but skipped
        emit(iWord(2, 3, 0, 9));
        emit(iWord(2, 4, 0, 4));
        emit(iWord(5, 0, 0, 1));
        emit(iWord(2, 6, 0, 1));
        emit(iWord(2, 5, 4, -1));
        emit(iWord(15, 0, 0, 0));
        runProgram(rnd ? "branchReady" : "branch", rnd);
    endtask

    task automatic trapTest();
        progLen = 0;
        emit(iWord(2, 1, 0, 3));
        emit(iWord(2, 2, 0, 4));
        emit(16'h7000);
        emit(iWord(2, 3, 0, 5));
        emit(iWord(15, 0, 0, 0));
        runProgram("trap", 1'b0);
        progLen = 0;
        emit(iWord(2, 1, 0, 6));
        emit(rWord(6, 2, 1, 1));                  // Unused funct
        emit(iWord(2, 3, 0, 5));
        runProgram("trapFunct", 1'b0);
    endtask

    initial begin
        resetReq    = 1'b0;
        imemReady   = 1'b1;
        randomReady = 1'b0;
        lcgState    = 32'd64;
        progLen     = 0;
        aluTest();
        memTest();
        depTest();
        branchTest(1'b0);
        trapTest();
        branchTest(1'b1);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/control.sv
rtl/proc.sv
sim/tbClock.sv
sim/proc_checker.sv
sim/procTb.sv
